// ==== source/soc_consts.svh ====
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4

// Memory map
`define DRAM_BASE 32'h8000_0000

// On-chip DRAM array size
`define DRAM_WORDS 256
`define DRAM_IDX_W 8

// Fixed access latencies in cycles
`define DRAM_READ_LAT 4
`define DRAM_WRITE_LAT 2

`endif

// ==== source/soc_pkg.sv ====
`include "soc_consts.svh"

package soc_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`STRB_W-1:0] strb_t;
    typedef logic [1:0]         resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // Shared by AW and AR
    typedef struct packed {
        addr_t addr;
    } axi_addr_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axi_w_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } axi_r_t;

    // Native bus to AXI bridge
    typedef enum logic [2:0] {
        BR_IDLE,
        BR_WRITE_ADDR_DATA,
        BR_WAIT_B,
        BR_READ_ADDR,
        BR_WAIT_R
    } bridge_state_t;

    // DRAM controller sequencing
    typedef enum logic [2:0] {
        DR_IDLE,
        DR_READ_WAIT,
        DR_READ_RESP,
        DR_WRITE_WAIT,
        DR_WRITE_RESP
    } dram_state_t;

endpackage

// ==== source/mem_axi_bridge.sv ====
`timescale 1ns/10ps

module mem_axi_bridge (
    input  logic               clk,
    input  logic               rst,
    // Native memory bus
    input  logic               mem_valid,
    input  soc_pkg::addr_t     mem_addr,
    input  soc_pkg::data_t     mem_wdata,
    input  soc_pkg::strb_t     mem_wstrb,
    output logic               mem_ready,
    output soc_pkg::data_t     mem_rdata,
    // Write address channel
    output soc_pkg::axi_addr_t aw,
    output logic               aw_valid,
    input  logic               aw_ready,
    // Write data channel
    output soc_pkg::axi_w_t    w,
    output logic               w_valid,
    input  logic               w_ready,
    // Write response channel
    input  soc_pkg::resp_t     b,
    input  logic               b_valid,
    output logic               b_ready,
    // Read address channel
    output soc_pkg::axi_addr_t ar,
    output logic               ar_valid,
    input  logic               ar_ready,
    // Read data channel
    input  soc_pkg::axi_r_t    r,
    input  logic               r_valid,
    output logic               r_ready,
    // Status
    output logic               bus_error
);
    import soc_pkg::*;

    bridge_state_t state;
    addr_t         req_addr;
    logic          accept;
    logic          b_done;
    logic          r_done;

    // mem_ready is still high in the cycle the request is being dropped
    assign accept = (state == BR_IDLE) && mem_valid && !mem_ready;
    assign b_done = (state == BR_WAIT_B) && b_valid;
    assign r_done = (state == BR_WAIT_R) && r_valid;

    assign aw      = '{addr: req_addr};
    assign ar      = '{addr: req_addr};
    assign b_ready = (state == BR_WAIT_B);
    assign r_ready = (state == BR_WAIT_R);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= BR_IDLE;
            aw_valid  <= 1'b0;
            w_valid   <= 1'b0;
            ar_valid  <= 1'b0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= 1'b0;
            case (state)
                BR_IDLE: begin
                    if (accept) begin
                        // Any enabled strobe marks a write
                        if (|mem_wstrb) begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            state    <= BR_WRITE_ADDR_DATA;
                        end else begin
                            ar_valid <= 1'b1;
                            state    <= BR_READ_ADDR;
                        end
                    end
                end
                BR_WRITE_ADDR_DATA: begin
                    // AW and W may complete in different cycles
                    if (aw_valid && aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_valid && w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if ((!aw_valid || aw_ready) && (!w_valid || w_ready)) begin
                        state <= BR_WAIT_B;
                    end
                end
                BR_WAIT_B: begin
                    if (b_done) begin
                        mem_ready <= 1'b1;
                        state     <= BR_IDLE;
                    end
                end
                BR_READ_ADDR: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        state    <= BR_WAIT_R;
                    end
                end
                BR_WAIT_R: begin
                    if (r_done) begin
                        mem_ready <= 1'b1;
                        state     <= BR_IDLE;
                    end
                end
                default: state <= BR_IDLE;
            endcase
        end
    end

    // Request payload captured once per access
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= mem_addr;
            w        <= '{data: mem_wdata, strb: mem_wstrb};
        end
        if (r_done) begin
            mem_rdata <= r.data;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            bus_error <= 1'b0;
        end else if ((b_done && b != RESP_OKAY) || (r_done && r.resp != RESP_OKAY)) begin
            bus_error <= 1'b1;
        end
    end

endmodule

// ==== source/axi_interconnect.sv ====
`timescale 1ns/10ps
`include "soc_consts.svh"

module axi_interconnect (
    input  logic               clk,
    input  logic               rst,
    // Upstream, from the bridge
    input  soc_pkg::axi_addr_t aw,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  soc_pkg::axi_w_t    w,
    input  logic               w_valid,
    output logic               w_ready,
    output soc_pkg::resp_t     b,
    output logic               b_valid,
    input  logic               b_ready,
    input  soc_pkg::axi_addr_t ar,
    input  logic               ar_valid,
    output logic               ar_ready,
    output soc_pkg::axi_r_t    r,
    output logic               r_valid,
    input  logic               r_ready,
    // Downstream, to the DRAM controller
    output soc_pkg::axi_addr_t dram_aw,
    output logic               dram_aw_valid,
    input  logic               dram_aw_ready,
    output soc_pkg::axi_w_t    dram_w,
    output logic               dram_w_valid,
    input  logic               dram_w_ready,
    input  soc_pkg::resp_t     dram_b,
    input  logic               dram_b_valid,
    output logic               dram_b_ready,
    output soc_pkg::axi_addr_t dram_ar,
    output logic               dram_ar_valid,
    input  logic               dram_ar_ready,
    input  soc_pkg::axi_r_t    dram_r,
    input  logic               dram_r_valid,
    output logic               dram_r_ready
);
    import soc_pkg::*;

    logic wr_active;
    logic wr_dram_q;
    logic rd_active;
    logic rd_dram_q;
    logic wr_dram;
    logic rd_dram;
    logic err_wr_accept;
    logic err_rd_accept;
    logic err_b_valid;
    logic err_r_valid;

    function automatic logic is_dram(addr_t addr);
        addr_t offset;
        offset = addr - `DRAM_BASE;
        return (addr >= `DRAM_BASE) && (offset[`ADDR_W-1:2] < `DRAM_WORDS);
    endfunction

    // Live decode until latched, the payload is stable while valid
    assign wr_dram = wr_active ? wr_dram_q : is_dram(aw.addr);
    assign rd_dram = rd_active ? rd_dram_q : is_dram(ar.addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_active <= 1'b0;
            rd_active <= 1'b0;
        end else begin
            if (!wr_active && aw_valid) begin
                wr_active <= 1'b1;
            end else if (b_valid && b_ready) begin
                wr_active <= 1'b0;
            end
            if (!rd_active && ar_valid) begin
                rd_active <= 1'b1;
            end else if (r_valid && r_ready) begin
                rd_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!wr_active) begin
            wr_dram_q <= wr_dram;
        end
        if (!rd_active) begin
            rd_dram_q <= rd_dram;
        end
    end

    // Write path
    assign dram_aw       = aw;
    assign dram_w        = w;
    assign dram_aw_valid = aw_valid && wr_dram;
    assign dram_w_valid  = w_valid && wr_dram;
    assign dram_b_ready  = b_ready && wr_dram;
    assign aw_ready      = wr_dram ? dram_aw_ready : err_wr_accept;
    assign w_ready       = wr_dram ? dram_w_ready : err_wr_accept;
    assign b             = wr_dram ? dram_b : RESP_DECERR;
    assign b_valid       = wr_dram ? dram_b_valid : err_b_valid;

    // Read path
    assign dram_ar       = ar;
    assign dram_ar_valid = ar_valid && rd_dram;
    assign dram_r_ready  = r_ready && rd_dram;
    assign ar_ready      = rd_dram ? dram_ar_ready : err_rd_accept;
    assign r             = rd_dram ? dram_r : '{data: '0, resp: RESP_DECERR};
    assign r_valid       = rd_dram ? dram_r_valid : err_r_valid;

    // Decode-error responder, takes AW and W together like the DRAM side
    assign err_wr_accept = !wr_dram && aw_valid && w_valid && !err_b_valid;
    assign err_rd_accept = !rd_dram && ar_valid && !err_r_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            err_b_valid <= 1'b0;
            err_r_valid <= 1'b0;
        end else begin
            if (err_wr_accept) begin
                err_b_valid <= 1'b1;
            end else if (err_b_valid && b_ready) begin
                err_b_valid <= 1'b0;
            end
            if (err_rd_accept) begin
                err_r_valid <= 1'b1;
            end else if (err_r_valid && r_ready) begin
                err_r_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== source/dram_controller.sv ====
`timescale 1ns/10ps
`include "soc_consts.svh"

module dram_controller (
    input  logic               clk,
    input  logic               rst,
    // Write address channel
    input  soc_pkg::axi_addr_t aw,
    input  logic               aw_valid,
    output logic               aw_ready,
    // Write data channel
    input  soc_pkg::axi_w_t    w,
    input  logic               w_valid,
    output logic               w_ready,
    // Write response channel
    output soc_pkg::resp_t     b,
    output logic               b_valid,
    input  logic               b_ready,
    // Read address channel
    input  soc_pkg::axi_addr_t ar,
    input  logic               ar_valid,
    output logic               ar_ready,
    // Read data channel
    output soc_pkg::axi_r_t    r,
    output logic               r_valid,
    input  logic               r_ready
);
    import soc_pkg::*;

    dram_state_t             state;
    logic [3:0]              lat_cnt;
    logic [`DRAM_IDX_W-1:0]  rd_idx;
    data_t                   rd_data;
    data_t                   mem [`DRAM_WORDS];
    logic                    wr_go;
    logic                    rd_go;

    // Address and data are only taken together
    assign wr_go    = (state == DR_IDLE) && aw_valid && w_valid;
    assign rd_go    = (state == DR_IDLE) && ar_valid && !wr_go;
    assign aw_ready = wr_go;
    assign w_ready  = wr_go;
    assign ar_ready = rd_go;

    assign b_valid = (state == DR_WRITE_RESP);
    assign b       = RESP_OKAY;
    assign r_valid = (state == DR_READ_RESP);
    assign r       = '{data: rd_data, resp: RESP_OKAY};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= DR_IDLE;
            lat_cnt <= '0;
        end else begin
            case (state)
                DR_IDLE: begin
                    if (wr_go) begin
                        lat_cnt <= 4'(`DRAM_WRITE_LAT - 1);
                        state   <= DR_WRITE_WAIT;
                    end else if (rd_go) begin
                        lat_cnt <= 4'(`DRAM_READ_LAT - 1);
                        state   <= DR_READ_WAIT;
                    end
                end
                DR_WRITE_WAIT: begin
                    lat_cnt <= lat_cnt - 4'd1;
                    if (lat_cnt == 4'd1) begin
                        state <= DR_WRITE_RESP;
                    end
                end
                DR_WRITE_RESP: begin
                    if (b_ready) begin
                        state <= DR_IDLE;
                    end
                end
                DR_READ_WAIT: begin
                    lat_cnt <= lat_cnt - 4'd1;
                    if (lat_cnt == 4'd1) begin
                        state <= DR_READ_RESP;
                    end
                end
                DR_READ_RESP: begin
                    if (r_ready) begin
                        state <= DR_IDLE;
                    end
                end
                default: state <= DR_IDLE;
            endcase
        end
    end

    // Word array with byte merge, read word fetched as the latency expires
    always_ff @(posedge clk) begin
        if (wr_go) begin
            for (int i = 0; i < `STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[aw.addr[`DRAM_IDX_W+1:2]][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
        if (rd_go) begin
            rd_idx <= ar.addr[`DRAM_IDX_W+1:2];
        end
        if (state == DR_READ_WAIT && lat_cnt == 4'd1) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

// ==== source/soc_top.sv ====
`timescale 1ns/10ps

module soc_top (
    input  logic           clk,
    input  logic           rst,
    // Native memory bus
    input  logic           mem_valid,
    input  soc_pkg::addr_t mem_addr,
    input  soc_pkg::data_t mem_wdata,
    input  soc_pkg::strb_t mem_wstrb,
    output logic           mem_ready,
    output soc_pkg::data_t mem_rdata,
    // Sticky error flag
    output logic           bus_error
);
    import soc_pkg::*;

    // Bridge side of the interconnect
    axi_addr_t cpu_aw, cpu_ar;
    axi_w_t    cpu_w;
    resp_t     cpu_b;
    axi_r_t    cpu_r;
    logic      cpu_aw_valid, cpu_aw_ready, cpu_w_valid, cpu_w_ready;
    logic      cpu_b_valid, cpu_b_ready, cpu_ar_valid, cpu_ar_ready;
    logic      cpu_r_valid, cpu_r_ready;

    // DRAM side of the interconnect
    axi_addr_t dram_aw, dram_ar;
    axi_w_t    dram_w;
    resp_t     dram_b;
    axi_r_t    dram_r;
    logic      dram_aw_valid, dram_aw_ready, dram_w_valid, dram_w_ready;
    logic      dram_b_valid, dram_b_ready, dram_ar_valid, dram_ar_ready;
    logic      dram_r_valid, dram_r_ready;

    mem_axi_bridge mem_axi_bridge_inst (
        .clk(clk), .rst(rst),
        .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .aw(cpu_aw), .aw_valid(cpu_aw_valid), .aw_ready(cpu_aw_ready),
        .w(cpu_w), .w_valid(cpu_w_valid), .w_ready(cpu_w_ready),
        .b(cpu_b), .b_valid(cpu_b_valid), .b_ready(cpu_b_ready),
        .ar(cpu_ar), .ar_valid(cpu_ar_valid), .ar_ready(cpu_ar_ready),
        .r(cpu_r), .r_valid(cpu_r_valid), .r_ready(cpu_r_ready),
        .bus_error(bus_error)
    );

    axi_interconnect axi_interconnect_inst (
        .clk(clk), .rst(rst),
        .aw(cpu_aw), .aw_valid(cpu_aw_valid), .aw_ready(cpu_aw_ready),
        .w(cpu_w), .w_valid(cpu_w_valid), .w_ready(cpu_w_ready),
        .b(cpu_b), .b_valid(cpu_b_valid), .b_ready(cpu_b_ready),
        .ar(cpu_ar), .ar_valid(cpu_ar_valid), .ar_ready(cpu_ar_ready),
        .r(cpu_r), .r_valid(cpu_r_valid), .r_ready(cpu_r_ready),
        .dram_aw(dram_aw), .dram_aw_valid(dram_aw_valid), .dram_aw_ready(dram_aw_ready),
        .dram_w(dram_w), .dram_w_valid(dram_w_valid), .dram_w_ready(dram_w_ready),
        .dram_b(dram_b), .dram_b_valid(dram_b_valid), .dram_b_ready(dram_b_ready),
        .dram_ar(dram_ar), .dram_ar_valid(dram_ar_valid), .dram_ar_ready(dram_ar_ready),
        .dram_r(dram_r), .dram_r_valid(dram_r_valid), .dram_r_ready(dram_r_ready)
    );

    dram_controller dram_controller_inst (
        .clk(clk), .rst(rst),
        .aw(dram_aw), .aw_valid(dram_aw_valid), .aw_ready(dram_aw_ready),
        .w(dram_w), .w_valid(dram_w_valid), .w_ready(dram_w_ready),
        .b(dram_b), .b_valid(dram_b_valid), .b_ready(dram_b_ready),
        .ar(dram_ar), .ar_valid(dram_ar_valid), .ar_ready(dram_ar_ready),
        .r(dram_r), .r_valid(dram_r_valid), .r_ready(dram_r_ready)
    );

endmodule

// ==== verification/soc_top_asserts.sv ====
`timescale 1ns/10ps
`include "soc_consts.svh"

module soc_top_asserts (
    input logic               clk,
    input logic               rst,
    input soc_pkg::axi_addr_t aw,
    input logic               aw_valid,
    input logic               aw_ready,
    input soc_pkg::axi_w_t    w,
    input logic               w_valid,
    input logic               w_ready,
    input soc_pkg::resp_t     b,
    input logic               b_valid,
    input logic               b_ready,
    input soc_pkg::axi_addr_t ar,
    input logic               ar_valid,
    input logic               ar_ready,
    input soc_pkg::axi_r_t    r,
    input logic               r_valid,
    input logic               r_ready
);
    import soc_pkg::*;

    logic  wr_pending;
    logic  rd_pending;
    addr_t wr_addr;
    addr_t rd_addr;

    // Offsets below DRAM_BASE wrap to large values and fall outside the window
    function automatic logic in_dram(addr_t addr);
        return addr_t'(addr - `DRAM_BASE) < `DRAM_WORDS * 4;
    endfunction

    // Requests accepted upstream and not yet answered
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_pending <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                wr_pending <= 1'b1;
                wr_addr    <= aw.addr;
            end else if (b_valid && b_ready) begin
                wr_pending <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                rd_pending <= 1'b1;
                rd_addr    <= ar.addr;
            end else if (r_valid && r_ready) begin
                rd_pending <= 1'b0;
            end
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("aw_valid dropped or aw changed before aw_ready");
    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("w_valid dropped or w changed before w_ready");
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("ar_valid dropped or ar changed before ar_ready");
    b_hold: assert property (@(posedge clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else $error("b_valid dropped or b changed before b_ready");
    r_hold: assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("r_valid dropped or r changed before r_ready");

    b_after_req: assert property (@(posedge clk) disable iff (rst)
        b_valid |-> wr_pending)
        else $error("b_valid without an accepted write");
    r_after_req: assert property (@(posedge clk) disable iff (rst)
        r_valid |-> rd_pending)
        else $error("r_valid without an accepted read");

    // OKAY for the DRAM window, DECERR for everything else
    b_code: assert property (@(posedge clk) disable iff (rst)
        b_valid |-> b == (in_dram(wr_addr) ? RESP_OKAY : RESP_DECERR))
        else $error("write response code %h does not fit address %h", b, wr_addr);
    r_code: assert property (@(posedge clk) disable iff (rst)
        r_valid |-> r.resp == (in_dram(rd_addr) ? RESP_OKAY : RESP_DECERR))
        else $error("read response code %h does not fit address %h", r.resp, rd_addr);

endmodule

bind axi_interconnect soc_top_asserts soc_top_asserts_inst (
    .clk(clk), .rst(rst),
    .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready),
    .b(b), .b_valid(b_valid), .b_ready(b_ready),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready)
);

// ==== verification/soc_top_tb.sv ====
`timescale 1ns/10ps

module soc_top_tb;
    import soc_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;

    logic  clk;
    logic  rst;
    logic  mem_valid;
    addr_t mem_addr;
    data_t mem_wdata;
    strb_t mem_wstrb;
    logic  mem_ready;
    data_t mem_rdata;
    logic  bus_error;

    int cur_test;
    int test_count;
    int fail_count;
    int test_errors;
    int test_accesses;
    bit timed_out;

    soc_top soc_top_inst (
        .clk(clk), .rst(rst),
        .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .bus_error(bus_error)
    );

    always #20 clk = ~clk;

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("FAIL test %0d: %s = %h, expected %h", cur_test, name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL test %0d: %s = %h, expected %h", cur_test, name, actual, expected);
            test_errors++;
        end
    endtask

    // One native-bus access; results sampled mid-cycle while mem_ready is high
    task automatic run_access(input bit is_write, input addr_t addr, input data_t wdata,
                              input strb_t strb, output bit done, output data_t rdata,
                              output logic err);
        int cycles;
        @(posedge clk);
        mem_valid <= 1'b1;
        mem_addr  <= addr;
        mem_wdata <= wdata;
        mem_wstrb <= is_write ? strb : '0;
        done   = 1'b0;
        cycles = 0;
        rdata  = '0;
        err    = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (mem_ready) begin
                done  = 1'b1;
                rdata = mem_rdata;
                err   = bus_error;
            end
        end
        @(posedge clk);
        mem_valid <= 1'b0;
        mem_wstrb <= '0;
    endtask

    task automatic report_test();
        if (test_accesses > 0) begin
            test_count++;
            if (test_errors == 0) begin
                $display("Test %0d: %0d accesses, ok", cur_test, test_accesses);
            end else begin
                $display("Test %0d: %0d accesses, %0d errors", cur_test, test_accesses,
                         test_errors);
                fail_count++;
            end
        end
        test_errors   = 0;
        test_accesses = 0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          line_test;
        int          exp_err;
        logic [63:0] op_word;
        addr_t       addr;
        data_t       wdata;
        strb_t       strb;
        data_t       exp_data;
        data_t       got_data;
        logic        got_err;
        string       line;
        bit          is_write;
        bit          done;

        void'($urandom(32'hed2acb2f));
        clk       = 1'b0;
        rst       = 1'b1;
        mem_valid = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        cur_test      = 0;
        test_count    = 0;
        fail_count    = 0;
        test_errors   = 0;
        test_accesses = 0;
        timed_out     = 1'b0;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("verification/soc_top_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            fail_count++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                // Skip comments and blank lines
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%d %s %h %h %h %h %d", line_test, op_word, addr, wdata,
                            strb, exp_data, exp_err);
                if (n != 7 || (op_word != "write" && op_word != "read")) begin
                    $display("Stimulus line could not be parsed: %s", line);
                    fail_count++;
                    continue;
                end
                if (line_test != cur_test) begin
                    report_test();
                    cur_test = line_test;
                end
                is_write = (op_word == "write");
                repeat ($urandom % 4) @(posedge clk);
                run_access(is_write, addr, wdata, strb, done, got_data, got_err);
                test_accesses++;
                if (!done) begin
                    $display("Test %0d: access to %h got no mem_ready within %0d cycles",
                             cur_test, addr, TIMEOUT_CYCLES);
                    test_errors++;
                    timed_out = 1'b1;
                end else begin
                    if (!is_write) begin
                        check_data("mem_rdata", got_data, exp_data);
                    end
                    check_flag("bus_error", got_err, exp_err != 0);
                end
            end
            $fclose(fd);
            report_test();
        end

        $display("Tests run: %0d, tests failed: %0d", test_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== soc_top.f ====
+incdir+source
source/soc_pkg.sv
source/mem_axi_bridge.sv
source/axi_interconnect.sv
source/dram_controller.sv
source/soc_top.sv
verification/soc_top_asserts.sv
verification/soc_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run; the log search decides the result
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module soc_top_tb \
    -f soc_top.f -o soc_top_sim &&
./obj_dir/soc_top_sim | tee sim.log
grep -q "All tests passed" sim.log && echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }

// ==== verification/soc_top_stimulus.txt ====
# test op address wdata strb exp_rdata exp_bus_error (all hex except test and bus_error)
# reads carry wdata and strb of zero; writes carry exp_rdata of zero
1 write 80000010 deadbeef f 00000000 0
1 read  80000010 00000000 0 deadbeef 0
2 write 80000020 11223344 f 00000000 0
2 write 80000020 000000aa 1 00000000 0
2 write 80000020 00cc0000 4 00000000 0
2 write 80000020 ee000000 8 00000000 0
2 read  80000020 00000000 0 eecc33aa 0
3 write 80000000 a5a5a5a5 f 00000000 0
3 write 800003fc 5a5a5a5a f 00000000 0
3 read  80000000 00000000 0 a5a5a5a5 0
3 read  800003fc 00000000 0 5a5a5a5a 0
4 write 80000100 01020304 f 00000000 0
4 write 80000104 a0b0c0d0 f 00000000 0
4 write 80000100 0000ff00 2 00000000 0
4 read  80000104 00000000 0 a0b0c0d0 0
4 read  80000100 00000000 0 0102ff04 0
4 write 80000010 cafef00d c 00000000 0
4 read  80000010 00000000 0 cafebeef 0
4 read  80000020 00000000 0 eecc33aa 0
5 read  00001000 00000000 0 00000000 1
5 read  80000000 00000000 0 a5a5a5a5 1
6 write 00000100 ffffffff f 00000000 1
6 read  80000100 00000000 0 0102ff04 1
